// ==== design/lvda_cfg.svh ====
`ifndef LVDA_CFG_SVH
`define LVDA_CFG_SVH

// ********************
// bus geometry
// ********************

// data bus and telemetry word width
`define LVDA_WORD_W 32
`define LVDA_ADR_W 2

// ********************
// serial line timing
// ********************

// clocks per serial bit
`define LVDA_BIT_CYCLES 4
// idle bit times after each frame
`define LVDA_GAP_BITS 2

// interval countdown
`define LVDA_CDN_W 16
`define LVDA_CDN_PRESCALE 8

`endif

// ==== design/lvda_tlm_pkg.sv ====
`include "lvda_cfg.svh"

package lvda_tlm_pkg;

    localparam int TLM_TAG_W  = 6;
    localparam int TLM_MEAS_W = `LVDA_WORD_W - TLM_TAG_W;

    // ********************
    // frame sequencer
    // ********************

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        SHIFT = 2'd1,
        GAP   = 2'd2
    } frame_state_e;

    // channel tag on top, measurement below, sent MSB first
    typedef struct packed {
        logic [TLM_TAG_W-1:0]  tag;
        logic [TLM_MEAS_W-1:0] meas;
    } tlm_word_t;

endpackage

// ==== design/lvda_bus_pkg.sv ====
`include "lvda_cfg.svh"

package lvda_bus_pkg;
    import lvda_tlm_pkg::*;

    // master side of a wishbone classic cycle
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`LVDA_ADR_W-1:0]   adr;
        logic [`LVDA_WORD_W-1:0]  dat_w;
    } wb_req_t;

    // register map
    typedef enum logic [`LVDA_ADR_W-1:0] {
        CDN_LOAD = 2'd0,
        TLM_WORD = 2'd1,
        STATUS   = 2'd2,
        INT_CLR  = 2'd3
    } lvda_reg_e;

    // write data seen as a countdown load or as a telemetry word
    typedef union packed {
        struct packed {
            logic [`LVDA_WORD_W-`LVDA_CDN_W-1:0] rsvd;
            logic [`LVDA_CDN_W-1:0]              load_val;
        } cdn;
        tlm_word_t tlm;
    } wr_word_u;

endpackage

// ==== design/lvda_bus_decode.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_bus_decode
    import lvda_bus_pkg::*;
    import lvda_tlm_pkg::*;
(
    input  logic                    sim_clk,
    input  logic                    rst_n,
    input  wb_req_t                 req,
    input  logic                    busy,
    input  logic                    intr_flag,
    input  logic [`LVDA_CDN_W-1:0]  count,
    output logic                    ack,
    output logic [`LVDA_WORD_W-1:0] dat_r,
    output logic                    cdn_load,
    output logic                    int_clr,
    output logic                    tlm_start,
    output logic [`LVDA_CDN_W-1:0]  load_val,
    output tlm_word_t               tlm_word
);

    localparam int PAD_W = `LVDA_WORD_W - `LVDA_CDN_W - 2;

    lvda_reg_e reg_sel;
    wr_word_u  wr_word;
    logic      req_valid;
    logic      tlm_hold;
    logic      wr_en;

    assign reg_sel   = lvda_reg_e'(req.adr);
    assign wr_word   = req.dat_w;
    assign req_valid = req.cyc && req.stb;
    // telemetry writes wait until the current frame and gap are done
    assign tlm_hold  = req.we && (reg_sel == TLM_WORD) && busy;

    // one-cycle ack that never repeats for the same request
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req_valid && !ack && !tlm_hold;
        end
    end

    // register effects land on the ack edge
    assign wr_en     = ack && req.we;
    assign cdn_load  = wr_en && (reg_sel == CDN_LOAD);
    assign int_clr   = wr_en && (reg_sel == INT_CLR);
    assign tlm_start = wr_en && (reg_sel == TLM_WORD);
    assign load_val  = wr_word.cdn.load_val;
    assign tlm_word  = wr_word.tlm;

    // count goes on top of the status word with busy and flag at the bottom
    always_comb begin
        dat_r = '0;
        if (ack && !req.we && (reg_sel == STATUS)) begin
            dat_r = {count, {PAD_W{1'b0}}, busy, intr_flag};
        end
    end

    // ack only inside a live bus cycle
    a_ack_in_cycle: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        ack |-> (req.cyc && req.stb)
    );

endmodule

// ==== design/lvda_frame_seq.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_frame_seq
    import lvda_tlm_pkg::*;
(
    input  logic sim_clk,
    input  logic rst_n,
    input  logic tlm_start,
    output logic load,
    output logic bit_strobe,
    output logic tlm_frame,
    output logic busy
);

    localparam int CNT_W = $clog2(`LVDA_BIT_CYCLES);
    localparam int IDX_W = $clog2(`LVDA_WORD_W);

    frame_state_e     state;
    logic [CNT_W-1:0] bit_cnt;
    logic [IDX_W-1:0] bit_idx;
    logic             bit_end;

    assign bit_end    = (bit_cnt == CNT_W'(`LVDA_BIT_CYCLES - 1));
    assign load       = (state == IDLE) && tlm_start;
    assign bit_strobe = (state == SHIFT) && bit_end;
    assign tlm_frame  = (state == SHIFT);
    assign busy       = (state != IDLE);

    // ********************
    // bit timing and state
    // ********************
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (tlm_start) state <= SHIFT;
                end
                SHIFT: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) begin
                        // bit index wraps to 0 after the last bit and the gap reuses it
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(`LVDA_WORD_W - 1)) state <= GAP;
                    end
                end
                GAP: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(`LVDA_GAP_BITS - 1)) state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the decoder holds telemetry writes while a frame is in flight
    a_no_start_busy: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        tlm_start |-> !busy
    );

endmodule

// ==== design/lvda_countdown.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_countdown (
    input  logic                   sim_clk,
    input  logic                   rst_n,
    input  logic                   cdn_load,
    input  logic                   int_clr,
    input  logic [`LVDA_CDN_W-1:0] load_val,
    output logic [`LVDA_CDN_W-1:0] count,
    output logic                   intr_flag
);

    localparam int PRE_W = $clog2(`LVDA_CDN_PRESCALE);

    logic [PRE_W-1:0] pre_cnt;
    logic             tick;

    // a zero count means stopped
    assign tick = (count != '0) && (pre_cnt == PRE_W'(`LVDA_CDN_PRESCALE - 1));

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt   <= '0;
            count     <= '0;
            intr_flag <= 1'b0;
        end else begin
            if (cdn_load) begin
                pre_cnt <= '0;
                count   <= load_val;
            end else if (count != '0) begin
                pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
                if (tick) count <= count - 1'b1;
            end

            // the flag is sticky until cleared and expiry wins over a clear in the same cycle
            if (int_clr) intr_flag <= 1'b0;
            if (!cdn_load && tick && (count == `LVDA_CDN_W'(1))) intr_flag <= 1'b1;
        end
    end

    // ********************
    // checks
    // ********************
    a_no_wrap: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        (count == '0 && !cdn_load) |=> (count == '0)
    );

endmodule

// ==== design/lvda_tlm_shifter.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_tlm_shifter
    import lvda_tlm_pkg::*;
(
    input  logic      sim_clk,
    input  logic      rst_n,
    input  logic      load,
    input  logic      bit_strobe,
    input  tlm_word_t tlm_word,
    output logic      tlm_data
);

    logic [`LVDA_WORD_W-1:0] shift_q;

    // ********************
    // MSB-first shift
    // ********************
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (load) begin
            shift_q <= tlm_word;
        end else if (bit_strobe) begin
            // zeros fill in behind, so the line idles low after the frame
            shift_q <= {shift_q[`LVDA_WORD_W-2:0], 1'b0};
        end
    end

    assign tlm_data = shift_q[`LVDA_WORD_W-1];

endmodule

// ==== design/lvda_top.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_top
    import lvda_bus_pkg::*;
    import lvda_tlm_pkg::*;
(
    input  logic                    sim_clk,
    input  logic                    rst_n,
    input  wb_req_t                 req,
    output logic                    ack,
    output logic                    tlm_data,
    output logic                    tlm_frame,
    output logic                    intr,
    output logic [`LVDA_WORD_W-1:0] dat_r
);

    logic                   busy;
    logic                   intr_flag;
    logic [`LVDA_CDN_W-1:0] count;
    logic                   cdn_load;
    logic                   int_clr;
    logic                   tlm_start;
    logic [`LVDA_CDN_W-1:0] load_val;
    tlm_word_t              tlm_word;
    logic                   load;
    logic                   bit_strobe;

    assign intr = intr_flag;

    // ********************
    // bus side
    // ********************
    lvda_bus_decode u_bus_decode (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .req       (req),
        .busy      (busy),
        .intr_flag (intr_flag),
        .count     (count),
        .ack       (ack),
        .dat_r     (dat_r),
        .cdn_load  (cdn_load),
        .int_clr   (int_clr),
        .tlm_start (tlm_start),
        .load_val  (load_val),
        .tlm_word  (tlm_word)
    );

    lvda_countdown u_countdown (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .cdn_load  (cdn_load),
        .int_clr   (int_clr),
        .load_val  (load_val),
        .count     (count),
        .intr_flag (intr_flag)
    );

    // serial telemetry
    lvda_frame_seq u_frame_seq (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .tlm_start  (tlm_start),
        .load       (load),
        .bit_strobe (bit_strobe),
        .tlm_frame  (tlm_frame),
        .busy       (busy)
    );

    lvda_tlm_shifter u_tlm_shifter (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .load       (load),
        .bit_strobe (bit_strobe),
        .tlm_word   (tlm_word),
        .tlm_data   (tlm_data)
    );

endmodule

// ==== tb/lvda_tb_model.svh ====
`ifndef LVDA_TB_MODEL_SVH
`define LVDA_TB_MODEL_SVH

// ********************
// serial frame model
// ********************

// words written to TLM_WORD and not yet seen on the line with the oldest first
logic [`LVDA_WORD_W-1:0] frame_q[$];

function automatic void model_tlm_write(logic [`LVDA_WORD_W-1:0] w);
    frame_q.push_back(w);
endfunction

// bit k of a frame carries word bit 31-k
function automatic logic model_frame_bit(int idx);
    return frame_q[0][`LVDA_WORD_W-1-idx];
endfunction

// ********************
// countdown model
// ********************

// highest count still allowed in STATUS, and the sticky flag
int cnt_ceiling = 0;
bit exp_flag = 1'b0;

function automatic void model_cdn_load(int n);
    cnt_ceiling = n;
endfunction

function automatic void model_count_seen(int c);
    cnt_ceiling = c;
endfunction

function automatic void model_expire();
    cnt_ceiling = 0;
    exp_flag = 1'b1;
endfunction

function automatic void model_int_clr();
    exp_flag = 1'b0;
endfunction

// cycles from the load edge to the rising interrupt
function automatic int min_rise(int n);
    return (n - 1) * `LVDA_CDN_PRESCALE;
endfunction

function automatic int max_rise(int n);
    return n * `LVDA_CDN_PRESCALE + 2;
endfunction

// status with the serializer idle and the counter stopped
function automatic logic [`LVDA_WORD_W-1:0] stopped_status();
    return {`LVDA_CDN_W'(cnt_ceiling), {(`LVDA_WORD_W-`LVDA_CDN_W-1){1'b0}}, exp_flag};
endfunction

`endif

// ==== tb/lvda_tb.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_tb
    import lvda_bus_pkg::*;
();

    localparam int ACK_LIMIT  = 200;
    localparam int POLL_LIMIT = 200;
    localparam int FRAME_CYC  = `LVDA_WORD_W * `LVDA_BIT_CYCLES;

    logic                    sim_clk;
    logic                    rst_n;
    wb_req_t                 req;
    logic                    ack;
    logic                    tlm_data;
    logic                    tlm_frame;
    logic                    intr;
    logic [`LVDA_WORD_W-1:0] dat_r;

    logic [31:0]             lfsr = 32'd34;
    int                      cyc_cnt = 0;
    int                      frame_len = 0;
    int                      intr_rise = -1;
    logic [`LVDA_WORD_W-1:0] rd;
    logic [`LVDA_WORD_W-1:0] word;
    int                      n;
    int                      load_cyc;
    int                      elapsed;

    `include "lvda_tb_model.svh"

    lvda_top uut (.*);

    initial begin
        sim_clk = 1'b0;
        forever #2 sim_clk = ~sim_clk;
    end

    always @(posedge sim_clk) cyc_cnt <= cyc_cnt + 1;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else
            stop_run($sformatf("FAIL t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp));
    endtask

    // one wishbone classic cycle that starts and ends on a falling edge
    task automatic bus_cycle(input logic we, input lvda_reg_e adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int wait_cyc;
        wait_cyc = 0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        req.dat_w = wdat;
        do begin
            @(negedge sim_clk);
            wait_cyc++;
            assert (wait_cyc < ACK_LIMIT) else stop_run("timeout: the bus slave gave no ack");
        end while (!ack);
        rdat = dat_r;
        // only telemetry writes may be held off
        if (!(we && adr == TLM_WORD)) check_val("ack delay", wait_cyc, 1);
        @(negedge sim_clk);
        check_val("ack", ack, 0);
        req = '0;
    endtask

    // ********************
    // line monitors
    // ********************
    always @(negedge sim_clk) begin
        if (rst_n && tlm_frame) begin
            assert (frame_q.size() != 0) else stop_run("a serial frame started with no word written");
            assert (frame_len < FRAME_CYC) else stop_run("tlm_frame stayed high past one word");
            if (frame_len % `LVDA_BIT_CYCLES == `LVDA_BIT_CYCLES / 2) begin
                check_val("tlm_data", tlm_data, model_frame_bit(frame_len / `LVDA_BIT_CYCLES));
            end
            frame_len++;
        end else if (frame_len != 0) begin
            check_val("tlm_frame length", frame_len, FRAME_CYC);
            void'(frame_q.pop_front());
            frame_len = 0;
        end
    end

    always @(negedge sim_clk) begin
        if (intr && intr_rise < 0) intr_rise = cyc_cnt;
    end

    initial begin
        rst_n = 1'b0;
        req = '0;
        repeat (3) @(negedge sim_clk);
        rst_n = 1'b1;
        check_val("ack", ack, 0);
        check_val("tlm_frame", tlm_frame, 0);
        check_val("tlm_data", tlm_data, 0);
        check_val("intr", intr, 0);
        bus_cycle(1'b0, STATUS, '0, rd);
        check_val("dat_r", rd, stopped_status());

        // back-to-back words where each later one is held off until the line is free
        for (int i = 0; i < 3; i++) begin
            word = take_bits(32);
            model_tlm_write(word);
            bus_cycle(1'b1, TLM_WORD, word, rd);
            if (i > 0) check_val("frames queued at ack", frame_q.size(), 1);
            bus_cycle(1'b0, STATUS, '0, rd);
            check_val("status busy", rd[1], 1);
        end
        for (int t = 0; frame_q.size() != 0; t++) begin
            assert (t < 2 * FRAME_CYC) else stop_run("timeout waiting for the last serial frame");
            @(negedge sim_clk);
        end

        // ********************
        // countdown
        // ********************
        for (int i = 0; i < 3; i++) begin
            n = take_bits(6) % 40 + 1;
            intr_rise = -1;
            bus_cycle(1'b1, CDN_LOAD, {take_bits(16), 16'(n)}, rd);
            load_cyc = cyc_cnt;
            model_cdn_load(n);
            for (int p = 0; !rd[0]; p++) begin
                assert (p < POLL_LIMIT) else stop_run("timeout waiting for the countdown to expire");
                bus_cycle(1'b0, STATUS, '0, rd);
                assert (rd[31:16] <= cnt_ceiling) else
                    stop_run($sformatf("FAIL t=%0t status count got=%0d exp<=%0d",
                                       $time, rd[31:16], cnt_ceiling));
                model_count_seen(rd[31:16]);
            end
            model_expire();
            check_val("status count at expiry", rd[31:16], 0);
            elapsed = intr_rise - load_cyc;
            assert (intr_rise >= 0 && elapsed >= min_rise(n) && elapsed <= max_rise(n)) else
                stop_run($sformatf("FAIL t=%0t intr delay got=%0d exp=%0d..%0d",
                                   $time, elapsed, min_rise(n), max_rise(n)));
            bus_cycle(1'b1, INT_CLR, '0, rd);
            model_int_clr();
            check_val("intr", intr, 0);
        end

        // a zero load on a running counter stops it without an interrupt
        n = take_bits(6) % 40 + 1;
        bus_cycle(1'b1, CDN_LOAD, {16'h0, 16'(n)}, rd);
        bus_cycle(1'b1, CDN_LOAD, '0, rd);
        model_cdn_load(0);
        for (int t = 0; t < max_rise(n) + `LVDA_CDN_PRESCALE; t++) begin
            @(negedge sim_clk);
            check_val("intr", intr, 0);
        end
        bus_cycle(1'b0, STATUS, '0, rd);
        check_val("dat_r", rd, stopped_status());

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
+incdir+tb
design/lvda_tlm_pkg.sv
design/lvda_bus_pkg.sv
design/lvda_bus_decode.sv
design/lvda_frame_seq.sv
design/lvda_countdown.sv
design/lvda_tlm_shifter.sv
design/lvda_top.sv
tb/lvda_tb.sv

// ==== Bender.yml ====
package:
  name: lvda_adapter

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/lvda_tlm_pkg.sv
      - design/lvda_bus_pkg.sv
      - design/lvda_bus_decode.sv
      - design/lvda_frame_seq.sv
      - design/lvda_countdown.sv
      - design/lvda_tlm_shifter.sv
      - design/lvda_top.sv
  - target: test
    include_dirs:
      - design
      - tb
    files:
      - tb/lvda_tb.sv
